// ==== hdl/uart_pkg.sv ====
//-----------------------------------------------------------
// UART shared definitions
// Oversampling rate, engine state encodings and the
// packed status word reported by the top level
//-----------------------------------------------------------
`default_nettype none

package uart_pkg;

    // Sample ticks per serial bit
    localparam int OVERSAMPLE = 16;

    //-----------------------------------------------------------
    // Engine states
    //-----------------------------------------------------------

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_START = 2'd1,
        RX_DATA  = 2'd2,
        RX_STOP  = 2'd3
    } rx_state_e;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_e;

    //-----------------------------------------------------------
    // Status
    //-----------------------------------------------------------

    // Error flags of both directions
    typedef struct packed {
        logic frame_err;
        logic rx_over_run;
        logic tx_over_run;
    } uart_status_t;

endpackage

`default_nettype wire

// ==== hdl/baud_tick_gen.sv ====
//-----------------------------------------------------------
// Baud tick generator
// Divides rx_clk into a sample tick at 16x the baud rate and
// a bit tick that lands on every sixteenth sample tick
//-----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen #(
    parameter int CLKS_PER_SAMPLE = 4
) (
    input  wire  rx_clk,
    input  wire  reset,
    output logic sample_tick,
    output logic bit_tick
);

    // Counter widths, at least one bit each
    localparam int CNT_W = (CLKS_PER_SAMPLE > 1) ? $clog2(CLKS_PER_SAMPLE) : 1;
    localparam int SMP_W = $clog2(uart_pkg::OVERSAMPLE);

    localparam logic [CNT_W-1:0] LAST_CLK    = CNT_W'(CLKS_PER_SAMPLE - 1);
    localparam logic [SMP_W-1:0] LAST_SAMPLE = SMP_W'(uart_pkg::OVERSAMPLE - 1);

    logic [CNT_W-1:0] clk_cnt;
    logic [SMP_W-1:0] sample_cnt;

    // Free running from reset so both engines share one time base
    always_ff @(posedge rx_clk or posedge reset) begin
        if (reset) begin
            clk_cnt     <= '0;
            sample_cnt  <= '0;
            sample_tick <= 1'b0;
            bit_tick    <= 1'b0;
        end else begin
            if (clk_cnt == LAST_CLK) begin
                clk_cnt     <= '0;
                sample_tick <= 1'b1;
                sample_cnt  <= sample_cnt + 1'b1;
                // Bit tick rides on the last sample of each bit
                bit_tick    <= (sample_cnt == LAST_SAMPLE);
            end else begin
                clk_cnt     <= clk_cnt + 1'b1;
                sample_tick <= 1'b0;
                bit_tick    <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_rx.sv ====
//-----------------------------------------------------------
// UART receiver, 8N1
// Synchronizes the serial line, finds the start edge, rejects
// false starts and samples each bit at its middle. A one-byte
// holder feeds the parallel side with rx_rdy and rx_ack, and
// frame errors and overruns are flagged per frame
//-----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire        rx_clk,
    input  wire        reset,
    input  wire        sample_tick,
    input  wire        rx_enable,
    input  wire        rx,
    output logic [7:0] rx_data,
    output logic       rx_rdy,
    input  wire        rx_ack,
    output logic       frame_err,
    output logic       rx_over_run
);

    localparam int SMP_W = $clog2(uart_pkg::OVERSAMPLE);

    // Eighth sample tick of a bit, counting the edge tick as the first
    localparam logic [SMP_W-1:0] MID_SAMPLE = SMP_W'(uart_pkg::OVERSAMPLE / 2 - 1);

    uart_pkg::rx_state_e state;

    logic             rx_d1;
    logic             rx_d2;
    logic             rx_last;
    logic [SMP_W-1:0] sample_cnt;
    logic [2:0]       bit_cnt;
    logic [7:0]       shift_reg;
    logic             rx_full;
    logic             at_mid;

    // Sampling point of the current bit
    assign at_mid = sample_tick && (sample_cnt == MID_SAMPLE);

    assign rx_rdy = rx_full;

    //-----------------------------------------------------------
    // Synchronizer and frame FSM
    //-----------------------------------------------------------

    always_ff @(posedge rx_clk or posedge reset) begin
        if (reset) begin
            rx_d1       <= 1'b1;
            rx_d2       <= 1'b1;
            rx_last     <= 1'b1;
            state       <= uart_pkg::RX_IDLE;
            sample_cnt  <= '0;
            bit_cnt     <= '0;
            rx_data     <= '0;
            rx_full     <= 1'b0;
            frame_err   <= 1'b0;
            rx_over_run <= 1'b0;
        end else begin
            // Two flops against metastability
            rx_d1 <= rx;
            rx_d2 <= rx_d1;

            // Line level at the previous sample tick, for edge detection
            if (sample_tick) begin
                rx_last <= rx_d2;
            end

            // Consumer empties the holder
            if (rx_ack) begin
                rx_full <= 1'b0;
            end

            if (!rx_enable) begin
                // Abort whatever frame is in flight
                state <= uart_pkg::RX_IDLE;
            end else if (sample_tick) begin
                if (state != uart_pkg::RX_IDLE) begin
                    sample_cnt <= sample_cnt + 1'b1;
                end

                case (state)
                    uart_pkg::RX_IDLE: begin
                        // Falling edge only, so a low stop bit cannot retrigger
                        if (rx_last && !rx_d2) begin
                            state      <= uart_pkg::RX_START;
                            sample_cnt <= SMP_W'(1);
                        end
                    end

                    uart_pkg::RX_START: begin
                        if (at_mid) begin
                            if (rx_d2) begin
                                // Glitch, not a start bit
                                state <= uart_pkg::RX_IDLE;
                            end else begin
                                state   <= uart_pkg::RX_DATA;
                                bit_cnt <= '0;
                            end
                        end
                    end

                    uart_pkg::RX_DATA: begin
                        if (at_mid) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) begin
                                state <= uart_pkg::RX_STOP;
                            end
                        end
                    end

                    uart_pkg::RX_STOP: begin
                        if (at_mid) begin
                            state <= uart_pkg::RX_IDLE;
                            if (!rx_d2) begin
                                // Bad stop bit, holder left alone
                                frame_err <= 1'b1;
                            end else begin
                                rx_data     <= shift_reg;
                                rx_full     <= 1'b1;
                                frame_err   <= 1'b0;
                                rx_over_run <= rx_full;
                            end
                        end
                    end

                    default: begin
                        state <= uart_pkg::RX_IDLE;
                    end
                endcase
            end
        end
    end

    //-----------------------------------------------------------
    // Data shifter
    //-----------------------------------------------------------

    // LSB arrives first, so shift in from the top
    always_ff @(posedge rx_clk) begin
        if (rx_enable && at_mid && (state == uart_pkg::RX_DATA)) begin
            shift_reg <= {rx_d2, shift_reg[7:1]};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
//-----------------------------------------------------------
// UART transmitter, 8N1
// Holds one byte loaded by tx_rdy and shifts it out as a
// start bit, eight data bits LSB first and a stop bit, one
// bit per bit tick. Loads into a full holder are dropped and
// flagged as an overrun
//-----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire        rx_clk,
    input  wire        reset,
    input  wire        bit_tick,
    input  wire        tx_enable,
    input  wire  [7:0] tx_data,
    input  wire        tx_rdy,
    output logic       tx_ack,
    output logic       tx,
    output logic       tx_over_run
);

    uart_pkg::tx_state_e state;

    logic [7:0] tx_reg;
    logic       tx_full;
    logic [2:0] bit_cnt;

    // Accept only into an empty holder
    assign tx_ack = tx_rdy && !tx_full;

    // Holding register
    always_ff @(posedge rx_clk) begin
        if (tx_ack) begin
            tx_reg <= tx_data;
        end
    end

    //-----------------------------------------------------------
    // Holder flags and frame FSM
    //-----------------------------------------------------------

    always_ff @(posedge rx_clk or posedge reset) begin
        if (reset) begin
            state       <= uart_pkg::TX_IDLE;
            tx_full     <= 1'b0;
            tx_over_run <= 1'b0;
            bit_cnt     <= '0;
            tx          <= 1'b1;
        end else begin
            if (tx_ack) begin
                tx_full <= 1'b1;
            end else if (tx_rdy) begin
                // Sticky until reset
                tx_over_run <= 1'b1;
            end

            if (!tx_enable) begin
                // Park the line, keep the byte for a full resend
                state   <= uart_pkg::TX_IDLE;
                bit_cnt <= '0;
                tx      <= 1'b1;
            end else if (bit_tick) begin
                case (state)
                    uart_pkg::TX_IDLE: begin
                        if (tx_full) begin
                            tx    <= 1'b0;
                            state <= uart_pkg::TX_START;
                        end
                    end

                    uart_pkg::TX_START: begin
                        tx      <= tx_reg[0];
                        bit_cnt <= '0;
                        state   <= uart_pkg::TX_DATA;
                    end

                    uart_pkg::TX_DATA: begin
                        if (bit_cnt == 3'd7) begin
                            tx    <= 1'b1;
                            state <= uart_pkg::TX_STOP;
                        end else begin
                            tx      <= tx_reg[bit_cnt + 3'd1];
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end

                    uart_pkg::TX_STOP: begin
                        // End of stop bit frees the holder
                        tx_full <= 1'b0;
                        bit_cnt <= '0;
                        state   <= uart_pkg::TX_IDLE;
                    end

                    default: begin
                        state <= uart_pkg::TX_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_top.sv ====
//-----------------------------------------------------------
// UART top level
// Single-clock 8N1 UART. One baud tick generator feeds the
// receiver and the transmitter, and their error flags are
// gathered into one status word
//-----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
    // rx_clk cycles per 16x sample tick
    parameter int CLKS_PER_SAMPLE = 4
) (
    input  wire                    rx_clk,
    input  wire                    reset,

    // Parallel transmit side
    input  wire  [7:0]             tx_data,
    input  wire                    tx_rdy,
    output logic                   tx_ack,

    // Parallel receive side
    output logic [7:0]             rx_data,
    output logic                   rx_rdy,
    input  wire                    rx_ack,

    // Direction enables
    input  wire                    tx_enable,
    input  wire                    rx_enable,

    // Serial lines
    input  wire                    rx,
    output logic                   tx,

    output uart_pkg::uart_status_t status
);

    logic sample_tick;
    logic bit_tick;
    logic frame_err;
    logic rx_over_run;
    logic tx_over_run;

    baud_tick_gen #(
        .CLKS_PER_SAMPLE (CLKS_PER_SAMPLE)
    ) baud_tick_gen_i (
        .rx_clk      (rx_clk),
        .reset       (reset),
        .sample_tick (sample_tick),
        .bit_tick    (bit_tick)
    );

    uart_rx uart_rx_i (
        .rx_clk      (rx_clk),
        .reset       (reset),
        .sample_tick (sample_tick),
        .rx_enable   (rx_enable),
        .rx          (rx),
        .rx_data     (rx_data),
        .rx_rdy      (rx_rdy),
        .rx_ack      (rx_ack),
        .frame_err   (frame_err),
        .rx_over_run (rx_over_run)
    );

    uart_tx uart_tx_i (
        .rx_clk      (rx_clk),
        .reset       (reset),
        .bit_tick    (bit_tick),
        .tx_enable   (tx_enable),
        .tx_data     (tx_data),
        .tx_rdy      (tx_rdy),
        .tx_ack      (tx_ack),
        .tx          (tx),
        .tx_over_run (tx_over_run)
    );

    // Flags of both engines in one word
    assign status = '{frame_err:   frame_err,
                      rx_over_run: rx_over_run,
                      tx_over_run: tx_over_run};

endmodule

`default_nettype wire

// ==== dv/uart_tb.sv ====
//-----------------------------------------------------------
// UART testbench
// Drives random serial frames into rx and random bytes into
// the transmit holder, decodes the tx line and checks data,
// handshakes and status flags against a queue-based model
//-----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

    localparam int CLKS_PER_SAMPLE = 4;
    localparam int BIT_CLKS        = CLKS_PER_SAMPLE * uart_pkg::OVERSAMPLE;
    localparam int HALF_BIT        = BIT_CLKS / 2;
    localparam int SEED            = 30807;
    localparam int TX_BYTES        = 20;
    localparam int RX_BYTES        = 20;

    // Directed frames: error test 2, overrun test 3, enable test 4 with the glitch window
    localparam int NUM_FRAMES      = TX_BYTES + RX_BYTES + 9;
    // Ten bits per frame plus up to one bit of start latency or idle gap
    localparam int TIMEOUT_CYCLES  = NUM_FRAMES * 11 * BIT_CLKS + 2000;

    logic                   rx_clk;
    logic                   reset;
    logic [7:0]             tx_data;
    logic                   tx_rdy;
    logic                   tx_ack;
    logic [7:0]             rx_data;
    logic                   rx_rdy;
    logic                   rx_ack;
    logic                   tx_enable;
    logic                   rx_enable;
    logic                   rx;
    logic                   tx;
    uart_pkg::uart_status_t status;

    // Reference model
    logic [7:0] rx_exp_q[$];
    logic [7:0] tx_exp_q[$];

    int         err_count   = 0;
    int         check_count = 0;
    int         tx_seen     = 0;
    int         cycle_cnt   = 0;
    logic       auto_ack    = 1'b1;
    logic [7:0] byte_a;
    logic [7:0] byte_b;
    int         errs_before;
    int         base;
    int         low_cnt;

    uart_top #(
        .CLKS_PER_SAMPLE (CLKS_PER_SAMPLE)
    ) uart_top_i (
        .rx_clk    (rx_clk),
        .reset     (reset),
        .tx_data   (tx_data),
        .tx_rdy    (tx_rdy),
        .tx_ack    (tx_ack),
        .rx_data   (rx_data),
        .rx_rdy    (rx_rdy),
        .rx_ack    (rx_ack),
        .tx_enable (tx_enable),
        .rx_enable (rx_enable),
        .rx        (rx),
        .tx        (tx),
        .status    (status)
    );

    always #5 rx_clk = ~rx_clk;

    //-----------------------------------------------------------
    // Helpers
    //-----------------------------------------------------------

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        $display("Test %-12s done, %0d error(s)", name, err_count - errs_at_start);
    endtask

    // Hold the rx line at one level for a number of cycles
    task automatic drive_line(input logic level, input int cycles);
        @(posedge rx_clk);
        #1;
        rx = level;
        repeat (cycles - 1) @(posedge rx_clk);
    endtask

    // Start bit, eight data bits LSB first, stop bit, idle
    task automatic send_frame(input logic [7:0] data, input logic stop_val, input int gap);
        drive_line(1'b0, BIT_CLKS);
        for (int i = 0; i < 8; i++) begin
            drive_line(data[i], BIT_CLKS);
        end
        drive_line(stop_val, BIT_CLKS);
        drive_line(1'b1, gap + 1);
    endtask

    task automatic load_tx(input logic [7:0] data, input logic exp_ack);
        @(posedge rx_clk);
        #1;
        tx_data = data;
        tx_rdy  = 1'b1;
        @(negedge rx_clk);
        check("tx_ack", tx_ack, exp_ack);
        @(posedge rx_clk);
        #1;
        tx_rdy = 1'b0;
    endtask

    task automatic pulse_rx_ack();
        @(posedge rx_clk);
        #1;
        rx_ack = 1'b1;
        @(posedge rx_clk);
        #1;
        rx_ack = 1'b0;
    endtask

    task automatic wait_tx_frames(input int count);
        while (tx_seen < count) begin
            @(posedge rx_clk);
        end
    endtask

    task automatic wait_rx_drained();
        while (rx_exp_q.size() != 0) begin
            @(posedge rx_clk);
        end
    endtask

    //-----------------------------------------------------------
    // Monitors
    //-----------------------------------------------------------

    // Decode tx from the start edge, sampling at mid-bit
    always begin : tx_monitor
        logic [7:0] got;
        logic       stop_bit;
        @(negedge rx_clk);
        if (!reset && tx === 1'b0) begin
            repeat (HALF_BIT) @(negedge rx_clk);
            if (tx !== 1'b0) begin
                $display("ERROR: tx start bit went high before mid-bit");
                err_count++;
            end else begin
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CLKS) @(negedge rx_clk);
                    got[i] = tx;
                end
                repeat (BIT_CLKS) @(negedge rx_clk);
                stop_bit = tx;
                check("tx stop bit", stop_bit, 1'b1);
                if (tx_exp_q.size() == 0) begin
                    $display("ERROR: byte 0x%0h sent on tx when none was expected", got);
                    err_count++;
                end else begin
                    check("tx byte", got, tx_exp_q.pop_front());
                end
                tx_seen++;
            end
        end
    end

    // Compare each received byte, then acknowledge it
    always begin : rx_checker
        @(negedge rx_clk);
        if (auto_ack && rx_rdy) begin
            if (rx_exp_q.size() == 0) begin
                $display("ERROR: rx_rdy rose with no frame expected");
                err_count++;
            end else begin
                check("rx_data", rx_data, rx_exp_q.pop_front());
            end
            check("frame_err", status.frame_err, 1'b0);
            check("rx_over_run", status.rx_over_run, 1'b0);
            pulse_rx_ack();
        end
    end

    always @(posedge rx_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("ERROR: run timed out after %0d cycles", cycle_cnt);
            $display("Verification failed");
            $finish;
        end
    end

    //-----------------------------------------------------------
    // Test sequence
    //-----------------------------------------------------------

    initial begin
        rx_clk    = 1'b0;
        reset     = 1'b1;
        tx_data   = '0;
        tx_rdy    = 1'b0;
        rx_ack    = 1'b0;
        tx_enable = 1'b1;
        rx_enable = 1'b1;
        rx        = 1'b1;
        void'($urandom(SEED));

        repeat (8) @(posedge rx_clk);
        #1;
        reset = 1'b0;
        @(negedge rx_clk);
        check("tx after reset", tx, 1'b1);
        check("rx_rdy after reset", rx_rdy, 1'b0);
        check("status after reset", status, 3'b000);
        check("rx_data after reset", rx_data, 8'h00);

        // 1. Random bytes out through the transmitter
        errs_before = err_count;
        for (int n = 0; n < TX_BYTES; n++) begin
            byte_a = 8'($urandom());
            tx_exp_q.push_back(byte_a);
            load_tx(byte_a, 1'b1);
            wait_tx_frames(n + 1);
            // Holder frees at the end of the stop bit
            repeat (HALF_BIT + 16) @(posedge rx_clk);
        end
        report_test("transmit", errs_before);

        // 2. Random frames into the receiver with random gaps
        errs_before = err_count;
        for (int n = 0; n < RX_BYTES; n++) begin
            byte_a = 8'($urandom());
            rx_exp_q.push_back(byte_a);
            send_frame(byte_a, 1'b1, $urandom() % 8);
        end
        wait_rx_drained();
        report_test("receive", errs_before);

        // 3. Bad stop bit, then a good frame
        errs_before = err_count;
        send_frame(8'($urandom()), 1'b0, 16);
        @(negedge rx_clk);
        check("frame_err", status.frame_err, 1'b1);
        check("rx_rdy", rx_rdy, 1'b0);
        byte_a = 8'($urandom());
        rx_exp_q.push_back(byte_a);
        send_frame(byte_a, 1'b1, 4);
        wait_rx_drained();
        report_test("frame error", errs_before);

        // 4. Receive and transmit overruns
        errs_before = err_count;
        auto_ack = 1'b0;
        byte_a   = 8'($urandom());
        byte_b   = ~byte_a;
        send_frame(byte_a, 1'b1, 0);
        send_frame(byte_b, 1'b1, 4);
        @(negedge rx_clk);
        check("rx_rdy", rx_rdy, 1'b1);
        check("rx_over_run", status.rx_over_run, 1'b1);
        check("rx_data", rx_data, byte_b);
        pulse_rx_ack();
        @(negedge rx_clk);
        check("rx_rdy after ack", rx_rdy, 1'b0);
        auto_ack = 1'b1;
        base = tx_seen;
        tx_exp_q.push_back(byte_a);
        load_tx(byte_a, 1'b1);
        load_tx(byte_b, 1'b0);
        @(negedge rx_clk);
        check("tx_over_run", status.tx_over_run, 1'b1);
        wait_tx_frames(base + 1);
        // The dropped byte must never start a frame
        low_cnt = 0;
        repeat (2 * BIT_CLKS) begin
            @(negedge rx_clk);
            if (tx !== 1'b1) begin
                low_cnt++;
            end
        end
        check("tx low cycles after frame", low_cnt, 0);
        report_test("overrun", errs_before);

        // 5. False start, disabled receiver, paused transmitter
        errs_before = err_count;
        drive_line(1'b0, HALF_BIT - 12);
        // Long enough for a wrongly accepted start to finish its frame
        drive_line(1'b1, 10 * BIT_CLKS);
        @(negedge rx_clk);
        check("rx_rdy after glitch", rx_rdy, 1'b0);
        @(posedge rx_clk);
        #1;
        rx_enable = 1'b0;
        send_frame(8'($urandom()), 1'b1, 8);
        @(negedge rx_clk);
        check("rx_rdy while disabled", rx_rdy, 1'b0);
        @(posedge rx_clk);
        #1;
        rx_enable = 1'b1;
        byte_a = 8'($urandom());
        rx_exp_q.push_back(byte_a);
        send_frame(byte_a, 1'b1, 4);
        wait_rx_drained();

        base = tx_seen;
        @(posedge rx_clk);
        #1;
        tx_enable = 1'b0;
        byte_b = 8'($urandom());
        tx_exp_q.push_back(byte_b);
        load_tx(byte_b, 1'b1);
        low_cnt = 0;
        repeat (160) begin
            @(negedge rx_clk);
            if (tx !== 1'b1) begin
                low_cnt++;
            end
        end
        check("tx low cycles while disabled", low_cnt, 0);
        @(posedge rx_clk);
        #1;
        tx_enable = 1'b1;
        wait_tx_frames(base + 1);
        report_test("enables", errs_before);

        // Nothing may be left in the model
        check("rx bytes left", rx_exp_q.size(), 0);
        check("tx bytes left", tx_exp_q.size(), 0);

        $display("Checks: %0d, errors: %0d, cycles: %0d", check_count, err_count, cycle_cnt);
        if (err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/uart_pkg.sv
hdl/baud_tick_gen.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_top.sv
dv/uart_tb.sv
